//--- src/rx_ctrl_pkg.sv
package rx_ctrl_pkg;

    // control packet layout, byte indexes count from 0
    // control word n sits at byte index n+1
    localparam int CTRL_PKT_LEN  = 40;
    localparam int PKT_NUM_BYTES = 2;
    localparam int CTRL_WORDS    = 32;
    localparam int CSUM_IDX      = 34;

    // counter widths
    localparam int BYTE_CNT_W   = 6;
    localparam int PKT_NUM_W    = 11;
    localparam int CTRL_PKT_NUM = 1;

    // field widths
    localparam int PANEL_W = 10;
    localparam int SIZE_W  = 11;
    localparam int BRT_W   = 7;
    localparam int FR_W    = 16;

    // frame-rate divider for 59.94 Hz
    localparam logic [FR_W-1:0] FR_RATE_DEFAULT = 16'd20854;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        CONTROL,
        TRAILER
    } pkt_phase_e;

    // field that the current byte belongs to
    typedef enum logic [4:0] {
        NONE, PNUM_LO, PNUM_HI,
        PANEL_LO, PANEL_HI, TOTAL_LO, TOTAL_HI, OUT_CH,
        HSIZE_LO, HSIZE_HI, VSIZE_LO, VSIZE_HI,
        BRT, GAMMA, CT_R, CT_G, CT_B,
        TEST_PAT, COLOR_LOSS, FR_LO, FR_HI, CSUM
    } ctrl_field_e;

endpackage

//--- src/rx_packet_timing.sv
`timescale 1ns/1ps

module rx_packet_timing import rx_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  qa_rstp,
    input  logic                  ovp,
    input  logic                  pac_stp,
    input  logic                  rx_dv,
    input  logic [7:0]            d,
    input  logic                  rx_er,
    output logic                  byte_valid,
    output logic [7:0]            byte_data,
    output logic                  rx_er_q,
    output ctrl_field_e           field_sel,
    output logic [BYTE_CNT_W-1:0] byte_count,
    output logic                  pkt_end
);

    logic [PKT_NUM_W-1:0] pkt_cnt;
    logic [PKT_NUM_W-1:0] pkt_cnt_nxt;
    pkt_phase_e           phase;
    ctrl_field_e          field_nxt;
    int                   word;

    // packet position in the frame, saturates at all ones
    always_comb begin
        pkt_cnt_nxt = pkt_cnt;
        if (ovp) begin
            pkt_cnt_nxt = '0;
        end else if (pac_stp && !(&pkt_cnt)) begin
            pkt_cnt_nxt = pkt_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            pkt_cnt <= '1;
        end else begin
            pkt_cnt <= pkt_cnt_nxt;
        end
    end

    // bytes so far, also the index of the byte now on d
    always_ff @(posedge clk) begin
        if (qa_rstp || pac_stp) begin
            byte_count <= '0;
        end else if (rx_dv && !(&byte_count)) begin
            byte_count <= byte_count + 1'b1;
        end
    end

    // only the control packet leaves IDLE
    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            phase <= IDLE;
        end else if (pac_stp) begin
            phase <= (pkt_cnt_nxt == PKT_NUM_W'(CTRL_PKT_NUM)) ? HEADER : IDLE;
        end else if (byte_valid && !rx_dv) begin
            phase <= IDLE;
        end else if (rx_dv) begin
            case (phase)
                HEADER:  phase <= (int'(byte_count) == PKT_NUM_BYTES - 1) ? CONTROL : HEADER;
                CONTROL: phase <= (int'(byte_count) == PKT_NUM_BYTES + CTRL_WORDS - 1) ?
                                  TRAILER : CONTROL;
                default: phase <= phase;
            endcase
        end
    end

    // byte index to field, by control word number
    always_comb begin
        field_nxt = NONE;
        word      = int'(byte_count) - 1;
        if (rx_dv) begin
            case (phase)
                HEADER:  field_nxt = (byte_count == '0) ? PNUM_LO : PNUM_HI;
                CONTROL: begin
                    case (word)
                        1:       field_nxt = PANEL_LO;
                        2:       field_nxt = PANEL_HI;
                        3:       field_nxt = TOTAL_LO;
                        4:       field_nxt = TOTAL_HI;
                        5:       field_nxt = OUT_CH;
                        6:       field_nxt = HSIZE_LO;
                        7:       field_nxt = HSIZE_HI;
                        8:       field_nxt = VSIZE_LO;
                        9:       field_nxt = VSIZE_HI;
                        11:      field_nxt = BRT;
                        12:      field_nxt = GAMMA;
                        13:      field_nxt = CT_R;
                        14:      field_nxt = CT_G;
                        15:      field_nxt = CT_B;
                        17:      field_nxt = TEST_PAT;
                        18:      field_nxt = COLOR_LOSS;
                        25:      field_nxt = FR_LO;
                        26:      field_nxt = FR_HI;
                        default: field_nxt = NONE;
                    endcase
                end
                TRAILER: field_nxt = (int'(byte_count) == CSUM_IDX) ? CSUM : NONE;
                default: field_nxt = NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            byte_valid <= 1'b0;
            rx_er_q    <= 1'b0;
            field_sel  <= NONE;
            pkt_end    <= 1'b0;
        end else begin
            byte_valid <= rx_dv;
            rx_er_q    <= rx_er;
            field_sel  <= field_nxt;
            // falling edge of registered rx_dv
            pkt_end    <= byte_valid && !rx_dv && (phase != IDLE);
        end
    end

    always_ff @(posedge clk) begin
        byte_data <= d;
    end

endmodule

//--- src/rx_packet_checker.sv
`timescale 1ns/1ps

module rx_packet_checker import rx_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  qa_rstp,
    input  logic                  rx_ok,
    input  logic                  byte_valid,
    input  logic [7:0]            byte_data,
    input  logic                  rx_er_q,
    input  ctrl_field_e           field_sel,
    input  logic [BYTE_CNT_W-1:0] byte_count,
    input  logic                  pkt_end,
    output logic                  commit,
    output logic                  pac1_ok,
    output logic                  ctrld_csum_ok
);

    logic [15:0] pkt_num;
    logic [7:0]  csum_rx;
    logic [7:0]  csum_acc;
    logic        er_seen;
    logic        in_ctrl_data;
    logic        accept;

    // byte_count already counts the byte on byte_data
    assign in_ctrl_data = byte_valid && (int'(byte_count) > PKT_NUM_BYTES) &&
                          (int'(byte_count) <= CSUM_IDX);

    // packet number and checksum byte as received
    always_ff @(posedge clk) begin
        if (field_sel == PNUM_LO) begin
            pkt_num[7:0] <= byte_data;
        end
        if (field_sel == PNUM_HI) begin
            pkt_num[15:8] <= byte_data;
        end
        if (field_sel == CSUM) begin
            csum_rx <= byte_data;
        end
    end

    // running sum and error latch restart with each control packet
    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            csum_acc <= '0;
            er_seen  <= 1'b0;
        end else if (field_sel == PNUM_LO) begin
            csum_acc <= '0;
            er_seen  <= rx_er_q;
        end else begin
            if (in_ctrl_data) begin
                csum_acc <= csum_acc + byte_data;
            end
            if (rx_er_q) begin
                er_seen <= 1'b1;
            end
        end
    end

    assign accept = rx_ok && (byte_count == BYTE_CNT_W'(CTRL_PKT_LEN)) && !er_seen &&
                    (pkt_num == 16'(CTRL_PKT_NUM));

    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            commit        <= 1'b0;
            pac1_ok       <= 1'b0;
            ctrld_csum_ok <= 1'b0;
        end else begin
            commit <= pkt_end && accept;
            if (pkt_end) begin
                pac1_ok       <= accept;
                // reported only, acceptance ignores it
                ctrld_csum_ok <= (csum_acc == csum_rx);
            end
        end
    end

endmodule

//--- src/ctrl_field_capture.sv
`timescale 1ns/1ps

module ctrl_field_capture import rx_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               qa_rstp,
    input  logic               byte_valid,
    input  logic [7:0]         byte_data,
    input  ctrl_field_e        field_sel,
    input  logic               commit,
    output logic [PANEL_W-1:0] panel_num,
    output logic [PANEL_W-1:0] total_panel,
    output logic [2:0]         out_ch,
    output logic [SIZE_W-1:0]  h_size,
    output logic [SIZE_W-1:0]  v_size,
    output logic [2:0]         color_loss,
    output logic [BRT_W-1:0]   rx_brt,
    output logic [2:0]         rx_gam,
    output logic [3:0]         rx_ct_r,
    output logic [3:0]         rx_ct_g,
    output logic [3:0]         rx_ct_b,
    output logic [7:0]         rx_test_pat,
    output logic [FR_W-1:0]    rx_fr_rate,
    output logic               rx_backup
);

    // staged fields, written as the bytes go by
    logic [7:0]         panel_lo;
    logic [PANEL_W-9:0] panel_hi;
    logic               backup_s;
    logic [7:0]         total_lo;
    logic [PANEL_W-9:0] total_hi;
    logic [2:0]         out_ch_s;
    logic [7:0]         hsize_lo;
    logic [SIZE_W-9:0]  hsize_hi;
    logic [7:0]         vsize_lo;
    logic [SIZE_W-9:0]  vsize_hi;
    logic [BRT_W-1:0]   brt_s;
    logic [2:0]         gam_s;
    logic [3:0]         ct_r_s;
    logic [3:0]         ct_g_s;
    logic [3:0]         ct_b_s;
    logic [7:0]         test_pat_s;
    logic [2:0]         cl_s;
    logic [7:0]         fr_lo;
    logic [7:0]         fr_hi;

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (field_sel)
                PANEL_LO:   panel_lo <= byte_data;
                PANEL_HI: begin
                    panel_hi <= byte_data[PANEL_W-9:0];
                    backup_s <= byte_data[6];
                end
                TOTAL_LO:   total_lo   <= byte_data;
                TOTAL_HI:   total_hi   <= byte_data[PANEL_W-9:0];
                OUT_CH:     out_ch_s   <= byte_data[2:0];
                HSIZE_LO:   hsize_lo   <= byte_data;
                HSIZE_HI:   hsize_hi   <= byte_data[SIZE_W-9:0];
                VSIZE_LO:   vsize_lo   <= byte_data;
                VSIZE_HI:   vsize_hi   <= byte_data[SIZE_W-9:0];
                BRT:        brt_s      <= byte_data[BRT_W-1:0];
                GAMMA:      gam_s      <= byte_data[2:0];
                CT_R:       ct_r_s     <= byte_data[3:0];
                CT_G:       ct_g_s     <= byte_data[3:0];
                CT_B:       ct_b_s     <= byte_data[3:0];
                TEST_PAT:   test_pat_s <= byte_data;
                COLOR_LOSS: cl_s       <= byte_data[2:0];
                FR_LO:      fr_lo      <= byte_data;
                FR_HI:      fr_hi      <= byte_data;
                default: ;
            endcase
        end
    end

    // all fields move together on an accepted packet
    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            panel_num   <= '0;
            total_panel <= '0;
            out_ch      <= '0;
            h_size      <= '0;
            v_size      <= '0;
            color_loss  <= '0;
            rx_brt      <= '0;
            rx_gam      <= '0;
            rx_ct_r     <= '0;
            rx_ct_g     <= '0;
            rx_ct_b     <= '0;
            rx_test_pat <= '0;
            rx_fr_rate  <= '0;
            rx_backup   <= 1'b0;
        end else if (commit) begin
            panel_num   <= {panel_hi, panel_lo};
            total_panel <= {total_hi, total_lo};
            out_ch      <= out_ch_s;
            h_size      <= {hsize_hi, hsize_lo};
            v_size      <= {vsize_hi, vsize_lo};
            color_loss  <= cl_s;
            rx_brt      <= brt_s;
            rx_gam      <= gam_s;
            rx_ct_r     <= ct_r_s;
            rx_ct_g     <= ct_g_s;
            rx_ct_b     <= ct_b_s;
            rx_test_pat <= test_pat_s;
            rx_fr_rate  <= {fr_hi, fr_lo};
            rx_backup   <= backup_s;
        end
    end

endmodule

//--- src/display_settings.sv
`timescale 1ns/1ps

module display_settings import rx_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             qa_rstp,
    input  logic             rx_ok,
    input  logic             pixel_disp_on,
    input  logic [3:0]       test_dsw,
    input  logic [7:0]       cmd_test_pat,
    input  logic [BRT_W-1:0] cmd_brightness,
    input  logic [2:0]       cmd_gamma,
    input  logic [3:0]       cmd_ct_red,
    input  logic [3:0]       cmd_ct_green,
    input  logic [3:0]       cmd_ct_blue,
    input  logic [BRT_W-1:0] rx_brt,
    input  logic [2:0]       rx_gam,
    input  logic [3:0]       rx_ct_r,
    input  logic [3:0]       rx_ct_g,
    input  logic [3:0]       rx_ct_b,
    input  logic [7:0]       rx_test_pat,
    input  logic [FR_W-1:0]  rx_fr_rate,
    input  logic             rx_backup,
    output logic [BRT_W-1:0] brightness,
    output logic [2:0]       gamma,
    output logic [3:0]       ct_red,
    output logic [3:0]       ct_green,
    output logic [3:0]       ct_blue,
    output logic [7:0]       test_pat,
    output logic [FR_W-1:0]  fr_rate,
    output logic             backup,
    output logic             color_loss_on_n
);

    logic       dsw_pat_on;
    logic       cmd_pat_on;
    logic [7:0] dsw_pat;
    logic [7:0] fallback_pat;

    assign dsw_pat_on = |test_dsw;
    // pattern groups 0x, 1x, 2x and 4x with a nonzero low nibble
    assign cmd_pat_on = (cmd_test_pat[6:4] inside {3'd0, 3'd1, 3'd2, 3'd4}) &&
                        (|cmd_test_pat[3:0]);
    // DIP switch is wired bit-reversed
    assign dsw_pat      = {4'h0, test_dsw[0], test_dsw[1], test_dsw[2], test_dsw[3]};
    assign fallback_pat = cmd_pat_on ? cmd_test_pat : dsw_pat;

    always_ff @(posedge clk) begin
        if (qa_rstp) begin
            brightness      <= '0;
            gamma           <= '0;
            ct_red          <= '0;
            ct_green        <= '0;
            ct_blue         <= '0;
            test_pat        <= '0;
            fr_rate         <= '0;
            backup          <= 1'b0;
            color_loss_on_n <= 1'b1;
        end else begin
            brightness <= rx_ok ? rx_brt : cmd_brightness;
            gamma      <= rx_ok ? rx_gam : cmd_gamma;
            ct_red     <= rx_ok ? rx_ct_r : cmd_ct_red;
            ct_green   <= rx_ok ? rx_ct_g : cmd_ct_green;
            ct_blue    <= rx_ok ? rx_ct_b : cmd_ct_blue;
            // pixel display mode blanks the pattern
            test_pat   <= pixel_disp_on ? 8'h00 : (rx_ok ? rx_test_pat : fallback_pat);
            fr_rate    <= rx_ok ? rx_fr_rate : FR_RATE_DEFAULT;
            backup     <= rx_ok && rx_backup;
            // low means no signal and nothing else to show
            color_loss_on_n <= rx_ok || pixel_disp_on || dsw_pat_on || cmd_pat_on;
        end
    end

endmodule

//--- src/rx_ctrl_top.sv
`timescale 1ns/1ps

module rx_ctrl_top import rx_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               qa_rstp,
    input  logic               ovp,
    input  logic               pac_stp,
    input  logic               rx_dv,
    input  logic [7:0]         d,
    input  logic               rx_er,
    input  logic               rx_ok,
    input  logic               pixel_disp_on,
    input  logic [3:0]         test_dsw,
    input  logic [7:0]         cmd_test_pat,
    input  logic [BRT_W-1:0]   cmd_brightness,
    input  logic [2:0]         cmd_gamma,
    input  logic [3:0]         cmd_ct_red,
    input  logic [3:0]         cmd_ct_green,
    input  logic [3:0]         cmd_ct_blue,
    output logic               ctrl_update,
    output logic               pac1_ok,
    output logic               ctrld_csum_ok,
    output logic [PANEL_W-1:0] panel_num,
    output logic [PANEL_W-1:0] total_panel,
    output logic [2:0]         out_ch,
    output logic [SIZE_W-1:0]  h_size,
    output logic [SIZE_W-1:0]  v_size,
    output logic [2:0]         color_loss,
    output logic [BRT_W-1:0]   brightness,
    output logic [2:0]         gamma,
    output logic [3:0]         ct_red,
    output logic [3:0]         ct_green,
    output logic [3:0]         ct_blue,
    output logic [7:0]         test_pat,
    output logic [FR_W-1:0]    fr_rate,
    output logic               backup,
    output logic               color_loss_on_n
);

    logic                  byte_valid;
    logic [7:0]            byte_data;
    logic                  rx_er_q;
    ctrl_field_e           field_sel;
    logic [BYTE_CNT_W-1:0] byte_count;
    logic                  pkt_end;

    // received settings, before the fallback select
    logic [BRT_W-1:0] rx_brt;
    logic [2:0]       rx_gam;
    logic [3:0]       rx_ct_r;
    logic [3:0]       rx_ct_g;
    logic [3:0]       rx_ct_b;
    logic [7:0]       rx_test_pat;
    logic [FR_W-1:0]  rx_fr_rate;
    logic             rx_backup;

    rx_packet_timing rx_packet_timing_i (
        .clk        (clk),
        .qa_rstp    (qa_rstp),
        .ovp        (ovp),
        .pac_stp    (pac_stp),
        .rx_dv      (rx_dv),
        .d          (d),
        .rx_er      (rx_er),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .rx_er_q    (rx_er_q),
        .field_sel  (field_sel),
        .byte_count (byte_count),
        .pkt_end    (pkt_end)
    );

    // commit drives ctrl_update directly
    rx_packet_checker rx_packet_checker_i (
        .clk           (clk),
        .qa_rstp       (qa_rstp),
        .rx_ok         (rx_ok),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .rx_er_q       (rx_er_q),
        .field_sel     (field_sel),
        .byte_count    (byte_count),
        .pkt_end       (pkt_end),
        .commit        (ctrl_update),
        .pac1_ok       (pac1_ok),
        .ctrld_csum_ok (ctrld_csum_ok)
    );

    ctrl_field_capture ctrl_field_capture_i (
        .clk         (clk),
        .qa_rstp     (qa_rstp),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .field_sel   (field_sel),
        .commit      (ctrl_update),
        .panel_num   (panel_num),
        .total_panel (total_panel),
        .out_ch      (out_ch),
        .h_size      (h_size),
        .v_size      (v_size),
        .color_loss  (color_loss),
        .rx_brt      (rx_brt),
        .rx_gam      (rx_gam),
        .rx_ct_r     (rx_ct_r),
        .rx_ct_g     (rx_ct_g),
        .rx_ct_b     (rx_ct_b),
        .rx_test_pat (rx_test_pat),
        .rx_fr_rate  (rx_fr_rate),
        .rx_backup   (rx_backup)
    );

    display_settings display_settings_i (
        .clk             (clk),
        .qa_rstp         (qa_rstp),
        .rx_ok           (rx_ok),
        .pixel_disp_on   (pixel_disp_on),
        .test_dsw        (test_dsw),
        .cmd_test_pat    (cmd_test_pat),
        .cmd_brightness  (cmd_brightness),
        .cmd_gamma       (cmd_gamma),
        .cmd_ct_red      (cmd_ct_red),
        .cmd_ct_green    (cmd_ct_green),
        .cmd_ct_blue     (cmd_ct_blue),
        .rx_brt          (rx_brt),
        .rx_gam          (rx_gam),
        .rx_ct_r         (rx_ct_r),
        .rx_ct_g         (rx_ct_g),
        .rx_ct_b         (rx_ct_b),
        .rx_test_pat     (rx_test_pat),
        .rx_fr_rate      (rx_fr_rate),
        .rx_backup       (rx_backup),
        .brightness      (brightness),
        .gamma           (gamma),
        .ct_red          (ct_red),
        .ct_green        (ct_green),
        .ct_blue         (ct_blue),
        .test_pat        (test_pat),
        .fr_rate         (fr_rate),
        .backup          (backup),
        .color_loss_on_n (color_loss_on_n)
    );

endmodule

//--- test/tb_rx_ctrl.sv
`timescale 1ns/1ps

module tb_rx_ctrl;

    logic        clk;
    logic        qa_rstp;
    logic        ovp;
    logic        pac_stp;
    logic        rx_dv;
    logic [7:0]  d;
    logic        rx_er;
    logic        rx_ok;
    logic        pixel_disp_on;
    logic [3:0]  test_dsw;
    logic [7:0]  cmd_test_pat;
    logic [6:0]  cmd_brightness;
    logic [2:0]  cmd_gamma;
    logic [3:0]  cmd_ct_red;
    logic [3:0]  cmd_ct_green;
    logic [3:0]  cmd_ct_blue;

    logic        ctrl_update;
    logic        pac1_ok;
    logic        ctrld_csum_ok;
    logic [9:0]  panel_num;
    logic [9:0]  total_panel;
    logic [2:0]  out_ch;
    logic [10:0] h_size;
    logic [10:0] v_size;
    logic [2:0]  color_loss;
    logic [6:0]  brightness;
    logic [2:0]  gamma;
    logic [3:0]  ct_red;
    logic [3:0]  ct_green;
    logic [3:0]  ct_blue;
    logic [7:0]  test_pat;
    logic [15:0] fr_rate;
    logic        backup;
    logic        color_loss_on_n;

    // packet being sent and the last packet the DUT should have accepted
    logic [7:0]  pkt [0:63];
    logic [7:0]  exp_pkt [0:63];
    logic [31:0] lcg_state;
    string       cur_test;
    int          test_errs;
    int          pass_count;
    int          fail_count;

    rx_ctrl_top rx_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // command pattern groups 0x, 1x, 2x, 4x with a nonzero low nibble
    function automatic logic cmd_pattern_on(input logic [7:0] tp);
        logic group_ok;
        case (tp[6:4])
            3'd0, 3'd1, 3'd2, 3'd4: group_ok = 1'b1;
            default: group_ok = 1'b0;
        endcase
        return group_ok && (tp[3:0] != 4'h0);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: passed", cur_test);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errs);
            fail_count++;
        end
    endtask

    task automatic check_eq(input string sig, input logic [31:0] expv,
                            input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, sig, expv, actv);
            test_errs++;
        end
    endtask

    // word n of the control data sits at byte n+1
    task automatic build_packet(input int len, input logic [15:0] pnum, input logic bad_csum);
        logic [7:0] sum;
        sum = 8'h00;
        for (int i = 0; i < 64; i++) begin
            pkt[6'(i)] = 8'h00;
            if (i < len) begin
                pkt[6'(i)] = lcg_byte();
            end
        end
        pkt[0] = pnum[7:0];
        pkt[1] = pnum[15:8];
        // backup flips against the last accepted packet
        pkt[3][6] = ~exp_pkt[3][6];
        for (int i = 2; i <= 33; i++) begin
            sum = sum + pkt[6'(i)];
        end
        pkt[34] = bad_csum ? ~sum : sum;
    endtask

    task automatic send_packet(input int len, input logic [15:0] pnum, input logic bad_csum,
                               input int er_idx, input logic new_frame);
        build_packet(len, pnum, bad_csum);
        if (new_frame) begin
            next_cycle();
            ovp = 1'b1;
            next_cycle();
            ovp = 1'b0;
        end
        next_cycle();
        pac_stp = 1'b1;
        next_cycle();
        pac_stp = 1'b0;
        for (int i = 0; i < len; i++) begin
            rx_dv = 1'b1;
            d     = pkt[6'(i)];
            rx_er = (i == er_idx);
            next_cycle();
        end
        rx_dv = 1'b0;
        d     = 8'h00;
        rx_er = 1'b0;
    endtask

    task automatic wait_update(input int limit, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            next_cycle();
            if (ctrl_update) begin
                seen = 1'b1;
            end
        end
    endtask

    // assumes rx_ok high and pixel_disp_on low
    task automatic check_fields();
        check_eq("panel_num", 32'({exp_pkt[3][1:0], exp_pkt[2]}), 32'(panel_num));
        check_eq("total_panel", 32'({exp_pkt[5][1:0], exp_pkt[4]}), 32'(total_panel));
        check_eq("out_ch", 32'(exp_pkt[6][2:0]), 32'(out_ch));
        check_eq("h_size", 32'({exp_pkt[8][2:0], exp_pkt[7]}), 32'(h_size));
        check_eq("v_size", 32'({exp_pkt[10][2:0], exp_pkt[9]}), 32'(v_size));
        check_eq("brightness", 32'(exp_pkt[12][6:0]), 32'(brightness));
        check_eq("gamma", 32'(exp_pkt[13][2:0]), 32'(gamma));
        check_eq("ct_red", 32'(exp_pkt[14][3:0]), 32'(ct_red));
        check_eq("ct_green", 32'(exp_pkt[15][3:0]), 32'(ct_green));
        check_eq("ct_blue", 32'(exp_pkt[16][3:0]), 32'(ct_blue));
        check_eq("test_pat", 32'(exp_pkt[18]), 32'(test_pat));
        check_eq("color_loss", 32'(exp_pkt[19][2:0]), 32'(color_loss));
        check_eq("fr_rate", 32'({exp_pkt[27], exp_pkt[26]}), 32'(fr_rate));
        check_eq("backup", 32'(exp_pkt[3][6]), 32'(backup));
    endtask

    task automatic expect_accept(input logic csum_good);
        logic seen;
        wait_update(16, seen);
        assert (seen) else begin
            $display("%s: timeout, ctrl_update never pulsed", cur_test);
            test_errs++;
        end
        check_eq("pac1_ok", 32'd1, 32'(pac1_ok));
        check_eq("ctrld_csum_ok", 32'(csum_good), 32'(ctrld_csum_ok));
        exp_pkt = pkt;
        // selected outputs trail commit by two cycles
        next_cycle();
        next_cycle();
        check_fields();
    endtask

    task automatic expect_reject(input logic pac1_exp);
        logic seen;
        wait_update(16, seen);
        assert (!seen) else begin
            $display("%s: ctrl_update pulsed for a packet that should be ignored", cur_test);
            test_errs++;
        end
        check_eq("pac1_ok", 32'(pac1_exp), 32'(pac1_ok));
        check_fields();
    endtask

    task automatic check_display(input logic [7:0] exp_tp, input logic exp_cl_n);
        check_eq("test_pat", 32'(exp_tp), 32'(test_pat));
        check_eq("color_loss_on_n", 32'(exp_cl_n), 32'(color_loss_on_n));
    endtask

    initial begin
        logic [7:0] r1;
        logic [7:0] r2;
        logic [7:0] tp_exp;
        logic       cl_exp;

        lcg_state      = 32'd65703;
        pass_count     = 0;
        fail_count     = 0;
        qa_rstp        = 1'b1;
        ovp            = 1'b0;
        pac_stp        = 1'b0;
        rx_dv          = 1'b0;
        d              = 8'h00;
        rx_er          = 1'b0;
        rx_ok          = 1'b1;
        pixel_disp_on  = 1'b0;
        test_dsw       = 4'h0;
        cmd_test_pat   = 8'h00;
        cmd_brightness = 7'h00;
        cmd_gamma      = 3'h0;
        cmd_ct_red     = 4'h0;
        cmd_ct_green   = 4'h0;
        cmd_ct_blue    = 4'h0;
        for (int i = 0; i < 64; i++) begin
            exp_pkt[6'(i)] = 8'h00;
        end
        repeat (10) next_cycle();
        qa_rstp = 1'b0;

        begin_test("reset");
        check_eq("ctrl_update", 32'd0, 32'(ctrl_update));
        check_eq("pac1_ok", 32'd0, 32'(pac1_ok));
        check_eq("ctrld_csum_ok", 32'd0, 32'(ctrld_csum_ok));
        check_fields();
        end_test();

        begin_test("valid_packet");
        send_packet(40, 16'd1, 1'b0, -1, 1'b1);
        expect_accept(1'b1);
        end_test();

        begin_test("bad_checksum");
        send_packet(40, 16'd1, 1'b1, -1, 1'b1);
        expect_accept(1'b0);
        end_test();

        begin_test("wrong_length");
        send_packet(39, 16'd1, 1'b0, -1, 1'b1);
        expect_reject(1'b0);
        send_packet(41, 16'd1, 1'b0, -1, 1'b1);
        expect_reject(1'b0);
        end_test();

        begin_test("rx_error");
        send_packet(40, 16'd1, 1'b0, 20, 1'b1);
        expect_reject(1'b0);
        end_test();

        begin_test("wrong_pkt_num");
        send_packet(40, 16'd3, 1'b0, -1, 1'b1);
        expect_reject(1'b0);
        end_test();

        // packet 2 of the same frame carries no control data
        begin_test("second_packet");
        send_packet(40, 16'd1, 1'b0, -1, 1'b1);
        expect_accept(1'b1);
        send_packet(40, 16'd2, 1'b0, -1, 1'b0);
        expect_reject(1'b1);
        end_test();

        begin_test("fallback");
        rx_ok          = 1'b0;
        r1             = lcg_byte();
        cmd_brightness = r1[6:0];
        r1             = lcg_byte();
        cmd_gamma      = r1[2:0];
        r1             = lcg_byte();
        cmd_ct_red     = r1[3:0];
        r1             = lcg_byte();
        cmd_ct_green   = r1[3:0];
        r1             = lcg_byte();
        cmd_ct_blue    = r1[3:0];
        cmd_test_pat   = 8'h23;
        test_dsw       = 4'b0011;
        next_cycle();
        check_eq("brightness", 32'(cmd_brightness), 32'(brightness));
        check_eq("gamma", 32'(cmd_gamma), 32'(gamma));
        check_eq("ct_red", 32'(cmd_ct_red), 32'(ct_red));
        check_eq("ct_green", 32'(cmd_ct_green), 32'(ct_green));
        check_eq("ct_blue", 32'(cmd_ct_blue), 32'(ct_blue));
        check_eq("fr_rate", 32'd20854, 32'(fr_rate));
        check_eq("backup", 32'd0, 32'(backup));
        check_eq("test_pat", 32'h23, 32'(test_pat));
        // group 3 is not a command pattern
        // DIP 0011 reads back as 1100
        cmd_test_pat = 8'h35;
        next_cycle();
        check_eq("test_pat", 32'h0c, 32'(test_pat));
        pixel_disp_on = 1'b1;
        next_cycle();
        check_eq("test_pat", 32'h00, 32'(test_pat));
        end_test();

        begin_test("color_loss");
        pixel_disp_on = 1'b0;
        test_dsw      = 4'h0;
        cmd_test_pat  = 8'h30;
        next_cycle();
        check_display(8'h00, 1'b0);
        for (int n = 0; n < 32; n++) begin
            r1            = lcg_byte();
            r2            = lcg_byte();
            rx_ok         = r1[0];
            pixel_disp_on = (r1[2:1] == 2'b00);
            test_dsw      = r1[7] ? r2[3:0] : 4'h0;
            cmd_test_pat  = lcg_byte();
            next_cycle();
            cl_exp = rx_ok || pixel_disp_on || (test_dsw != 4'h0) ||
                     cmd_pattern_on(cmd_test_pat);
            if (pixel_disp_on) begin
                tp_exp = 8'h00;
            end else if (rx_ok) begin
                tp_exp = exp_pkt[18];
            end else if (cmd_pattern_on(cmd_test_pat)) begin
                tp_exp = cmd_test_pat;
            end else begin
                tp_exp = {4'h0, test_dsw[0], test_dsw[1], test_dsw[2], test_dsw[3]};
            end
            check_display(tp_exp, cl_exp);
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
src/rx_ctrl_pkg.sv
src/rx_packet_timing.sv
src/rx_packet_checker.sv
src/ctrl_field_capture.sv
src/display_settings.sv
src/rx_ctrl_top.sv
test/tb_rx_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
    --top-module tb_rx_ctrl \
    -f project.f \
    --Mdir obj_dir \
    -o tb_rx_ctrl

./obj_dir/tb_rx_ctrl | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
echo "simulation reported failures, see sim.log"
exit 1
